//--- controller_config.svh
`ifndef CONTROLLER_CONFIG_SVH
`define CONTROLLER_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Register map
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CTL_ADDR_CTL_FLAG        8'h00
`define CTL_ADDR_FPGA_STATE      8'h01
`define CTL_ADDR_VERSION_MAJOR   8'h02
`define CTL_ADDR_VERSION_MINOR   8'h03
`define CTL_ADDR_SILENCER_BASE   8'h40  // Five words
`define CTL_ADDR_SYNC_BASE       8'h50  // Six words

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Control-flag bits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CTL_FLAG_FORCE_FAN       0
`define CTL_FLAG_SILENCER_SET    3
`define CTL_FLAG_SYNC_SET        4

// Firmware version
`define CTL_VERSION_MAJOR        8'h0a
`define CTL_VERSION_MINOR        8'h00

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Payload reset values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`define CTL_SILENCER_MODE_FIXED_STEPS 16'd0

// Lowest word first: mode, rate int, rate phase, steps int, steps phase
`define CTL_SILENCER_DEFAULT {16'd40, 16'd10, 16'd1, 16'd1, `CTL_SILENCER_MODE_FIXED_STEPS}

// Sync time in the low 64 bits, base count above it
`define CTL_SYNC_DEFAULT     {32'd10240, 64'd0}

// Register memory read latency in cycles
`define CTL_RD_LATENCY           2

`endif

//--- controller_pkg.sv
`default_nettype none

package controller_pkg;

    typedef logic [15:0] bus_word_t;  // One register word
    typedef logic [7:0]  bus_addr_t;

    // Five words, mode lands in the lowest word
    typedef struct packed {
        logic [15:0] completion_steps_phase;
        logic [15:0] completion_steps_intensity;
        logic [15:0] update_rate_phase;
        logic [15:0] update_rate_intensity;
        logic [15:0] mode;                       // Only bit 0 used
    } silencer_settings_t;

    // Six words, sync time in words 0 to 3
    typedef struct packed {
        logic [31:0] base_cnt;
        logic [63:0] sync_time;
    } sync_settings_t;

endpackage

`default_nettype wire

//--- cnt_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

`include "controller_config.svh"

module cnt_bus_arbiter (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      req_0,
    input  logic                      we_0,
    input  controller_pkg::bus_addr_t addr_0,
    input  controller_pkg::bus_word_t wdata_0,
    output logic                      gnt_0,
    output logic                      rvalid_0,
    input  logic                      req_1,
    input  logic                      we_1,
    input  controller_pkg::bus_addr_t addr_1,
    input  controller_pkg::bus_word_t wdata_1,
    output logic                      gnt_1,
    output logic                      rvalid_1,
    input  logic                      req_2,
    input  logic                      we_2,
    input  controller_pkg::bus_addr_t addr_2,
    input  controller_pkg::bus_word_t wdata_2,
    output logic                      gnt_2,
    output logic                      rvalid_2,
    output controller_pkg::bus_word_t rdata,
    output logic                      mem_we,
    output controller_pkg::bus_addr_t mem_addr,
    output controller_pkg::bus_word_t mem_wdata,
    input  controller_pkg::bus_word_t mem_rdata
);
    import controller_pkg::*;

    localparam int N_REQ = 3;
    localparam int LAT   = `CTL_RD_LATENCY;

    logic [N_REQ-1:0]          req;
    logic [N_REQ-1:0]          we;
    logic [N_REQ-1:0]          gnt;
    bus_addr_t                 addr  [N_REQ];
    bus_word_t                 wdata [N_REQ];
    logic [LAT-1:0][N_REQ-1:0] tag_q;  // Owner of each read in flight

    assign req   = {req_2, req_1, req_0};
    assign we    = {we_2, we_1, we_0};
    assign addr  = '{addr_0, addr_1, addr_2};
    assign wdata = '{wdata_0, wdata_1, wdata_2};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fixed priority, lowest index wins
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign gnt[0] = req[0];
    assign gnt[1] = req[1] & ~req[0];
    assign gnt[2] = req[2] & ~req[1] & ~req[0];

    assign {gnt_2, gnt_1, gnt_0} = gnt;

    // Granted requester owns the bus in its grant cycle
    always_comb begin
        mem_we    = 1'b0;
        mem_addr  = '0;
        mem_wdata = '0;
        for (int i = 0; i < N_REQ; i++) begin
            if (gnt[i]) begin
                mem_we    = we[i];
                mem_addr  = addr[i];
                mem_wdata = wdata[i];
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Read return routing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            tag_q <= '0;
        end else begin
            tag_q[0] <= gnt & ~we;
            for (int i = 1; i < LAT; i++) begin
                tag_q[i] <= tag_q[i-1];
            end
        end
    end

    assign {rvalid_2, rvalid_1, rvalid_0} = tag_q[LAT-1];
    assign rdata = mem_rdata;  // Shared, qualified by rvalid

    a_gnt_onehot: assert property (@(posedge CLK) disable iff (!rst_n) $onehot0(gnt));

endmodule

`default_nettype wire

//--- settings_loader.sv
`timescale 1ns/1ps
`default_nettype none

module settings_loader #(
    parameter type                       payload_t   = logic [15:0],
    parameter payload_t                  RESET_VALUE = '0,
    parameter controller_pkg::bus_addr_t BASE_ADDR   = '0
) (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      start,
    output logic                      req,
    output controller_pkg::bus_addr_t addr,
    input  logic                      gnt,
    input  logic                      rvalid,
    input  controller_pkg::bus_word_t rdata,
    output payload_t                  settings,
    output logic                      update
);
    import controller_pkg::*;

    localparam int WORD_W    = $bits(bus_word_t);
    localparam int PAYLOAD_W = $bits(payload_t);
    localparam int NWORDS    = PAYLOAD_W / WORD_W;
    localparam int CNT_W     = $clog2(NWORDS + 1);

    logic                 busy;
    logic [CNT_W-1:0]     issue_cnt;  // Reads granted so far
    logic [CNT_W-1:0]     recv_cnt;   // Words stored so far
    logic [PAYLOAD_W-1:0] data_q;

    assign addr     = bus_addr_t'(BASE_ADDR + bus_addr_t'(issue_cnt));
    assign settings = payload_t'(data_q);

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            busy      <= 1'b0;
            req       <= 1'b0;
            issue_cnt <= '0;
            recv_cnt  <= '0;
            update    <= 1'b0;
            data_q    <= RESET_VALUE;
        end else begin
            update <= 1'b0;
            if (start && !busy) begin
                busy      <= 1'b1;
                req       <= 1'b1;
                issue_cnt <= '0;
                recv_cnt  <= '0;
            end else if (gnt) begin
                issue_cnt <= issue_cnt + 1'b1;
                if (issue_cnt == CNT_W'(NWORDS - 1)) begin
                    req <= 1'b0;  // Last address is out
                end
            end
            if (rvalid) begin
                data_q[recv_cnt*WORD_W +: WORD_W] <= rdata;
                recv_cnt <= recv_cnt + 1'b1;
                if (recv_cnt == CNT_W'(NWORDS - 1)) begin
                    busy   <= 1'b0;
                    update <= 1'b1;
                end
            end
        end
    end

    a_rvalid_busy: assert property (@(posedge CLK) disable iff (!rst_n) rvalid |-> busy);

endmodule

`default_nettype wire

//--- ctl_poller.sv
`timescale 1ns/1ps
`default_nettype none

`include "controller_config.svh"

module ctl_poller (
    input  logic                      CLK,
    input  logic                      rst_n,
    input  logic                      thermo,
    input  logic                      mod_segment,
    input  logic                      stm_segment,
    input  logic [15:0]               stm_cycle,
    output logic                      req,
    output logic                      we,
    output controller_pkg::bus_addr_t addr,
    output controller_pkg::bus_word_t wdata,
    input  logic                      gnt,
    input  logic                      rvalid,
    input  controller_pkg::bus_word_t rdata,
    output logic                      silencer_start,
    output logic                      sync_start,
    input  logic                      silencer_done,
    input  logic                      sync_done,
    output logic                      force_fan
);
    import controller_pkg::*;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_VER_MINOR,
        ST_VER_MAJOR,
        ST_RD_FLAG,
        ST_WR_STATE,
        ST_WAIT_FLAG,
        ST_LOAD,
        ST_WR_FLAG
    } state_t;

    state_t    state;
    bus_word_t flags_q;
    bus_word_t status_word;
    logic      rd_pending;      // Flag read granted, data not back yet
    logic      serve_sync;      // Which loader is running
    logic      loader_running;

    assign status_word = {12'h000, (stm_cycle == 16'h0000), stm_segment, mod_segment, thermo};
    assign force_fan   = flags_q[`CTL_FLAG_FORCE_FAN];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Bus request per state
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        req   = 1'b0;
        we    = 1'b0;
        addr  = '0;
        wdata = '0;
        case (state)
            ST_VER_MINOR: begin
                req   = 1'b1;
                we    = 1'b1;
                addr  = `CTL_ADDR_VERSION_MINOR;
                wdata = {8'h00, `CTL_VERSION_MINOR};
            end
            ST_VER_MAJOR: begin
                req   = 1'b1;
                we    = 1'b1;
                addr  = `CTL_ADDR_VERSION_MAJOR;
                wdata = {8'h00, `CTL_VERSION_MAJOR};
            end
            ST_RD_FLAG: begin
                req  = 1'b1;
                addr = `CTL_ADDR_CTL_FLAG;
            end
            ST_WR_STATE: begin
                req   = 1'b1;
                we    = 1'b1;
                addr  = `CTL_ADDR_FPGA_STATE;
                wdata = status_word;
            end
            ST_WR_FLAG: begin
                req   = 1'b1;
                we    = 1'b1;
                addr  = `CTL_ADDR_CTL_FLAG;
                wdata = flags_q;  // Served bit already cleared
            end
            default: ;
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Poll FSM
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            state          <= ST_IDLE;
            flags_q        <= '0;
            rd_pending     <= 1'b0;
            serve_sync     <= 1'b0;
            silencer_start <= 1'b0;
            sync_start     <= 1'b0;
        end else begin
            silencer_start <= 1'b0;
            sync_start     <= 1'b0;
            if (rvalid) begin
                flags_q    <= rdata;
                rd_pending <= 1'b0;
            end
            case (state)
                ST_IDLE:      state <= ST_VER_MINOR;
                ST_VER_MINOR: if (gnt) state <= ST_VER_MAJOR;
                ST_VER_MAJOR: if (gnt) state <= ST_RD_FLAG;
                ST_RD_FLAG: begin
                    if (gnt) begin
                        rd_pending <= 1'b1;
                        state      <= ST_WR_STATE;
                    end
                end
                ST_WR_STATE:  if (gnt) state <= ST_WAIT_FLAG;
                ST_WAIT_FLAG: begin
                    if (!rd_pending) begin
                        if (flags_q[`CTL_FLAG_SILENCER_SET]) begin  // Silencer goes first
                            silencer_start <= 1'b1;
                            serve_sync     <= 1'b0;
                            state          <= ST_LOAD;
                        end else if (flags_q[`CTL_FLAG_SYNC_SET]) begin
                            sync_start <= 1'b1;
                            serve_sync <= 1'b1;
                            state      <= ST_LOAD;
                        end else begin
                            state <= ST_RD_FLAG;
                        end
                    end
                end
                ST_LOAD: begin
                    if (serve_sync ? sync_done : silencer_done) begin
                        flags_q[serve_sync ? `CTL_FLAG_SYNC_SET : `CTL_FLAG_SILENCER_SET] <= 1'b0;
                        state <= ST_WR_FLAG;
                    end
                end
                ST_WR_FLAG:   if (gnt) state <= ST_RD_FLAG;
                default:      state <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (!rst_n) begin
            loader_running <= 1'b0;
        end else if (silencer_start || sync_start) begin
            loader_running <= 1'b1;
        end else if (silencer_done || sync_done) begin
            loader_running <= 1'b0;
        end
    end

    a_one_loader: assert property (@(posedge CLK) disable iff (!rst_n)
        (silencer_start || sync_start) |-> !loader_running);

endmodule

`default_nettype wire

//--- controller_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "controller_config.svh"

module controller_top (
    input  logic                               CLK,
    input  logic                               rst_n,
    input  logic                               thermo,
    input  logic                               mod_segment,
    input  logic                               stm_segment,
    input  logic [15:0]                        stm_cycle,
    output logic                               mem_we,
    output controller_pkg::bus_addr_t          mem_addr,
    output controller_pkg::bus_word_t          mem_wdata,
    input  controller_pkg::bus_word_t          mem_rdata,
    output controller_pkg::silencer_settings_t silencer_settings,
    output logic                               silencer_update,
    output controller_pkg::sync_settings_t     sync_settings,
    output logic                               sync_update,
    output logic                               force_fan
);
    import controller_pkg::*;

    logic      sil_req, sil_gnt, sil_rvalid, sil_start;
    logic      sync_req, sync_gnt, sync_rvalid, sync_start;
    logic      pol_req, pol_we, pol_gnt, pol_rvalid;
    bus_addr_t sil_addr, sync_addr, pol_addr;
    bus_word_t pol_wdata, rdata;

    settings_loader #(
        .payload_t   (silencer_settings_t),
        .RESET_VALUE (silencer_settings_t'(`CTL_SILENCER_DEFAULT)),
        .BASE_ADDR   (`CTL_ADDR_SILENCER_BASE)
    ) i_silencer_loader (
        .CLK(CLK), .rst_n(rst_n), .start(sil_start),
        .req(sil_req), .addr(sil_addr), .gnt(sil_gnt), .rvalid(sil_rvalid), .rdata(rdata),
        .settings(silencer_settings), .update(silencer_update)
    );

    settings_loader #(
        .payload_t   (sync_settings_t),
        .RESET_VALUE (sync_settings_t'(`CTL_SYNC_DEFAULT)),
        .BASE_ADDR   (`CTL_ADDR_SYNC_BASE)
    ) i_sync_loader (
        .CLK(CLK), .rst_n(rst_n), .start(sync_start),
        .req(sync_req), .addr(sync_addr), .gnt(sync_gnt), .rvalid(sync_rvalid), .rdata(rdata),
        .settings(sync_settings), .update(sync_update)
    );

    ctl_poller i_ctl_poller (
        .CLK(CLK), .rst_n(rst_n),
        .thermo(thermo), .mod_segment(mod_segment), .stm_segment(stm_segment),
        .stm_cycle(stm_cycle),
        .req(pol_req), .we(pol_we), .addr(pol_addr), .wdata(pol_wdata),
        .gnt(pol_gnt), .rvalid(pol_rvalid), .rdata(rdata),
        .silencer_start(sil_start), .sync_start(sync_start),
        .silencer_done(silencer_update), .sync_done(sync_update),  // Update doubles as done
        .force_fan(force_fan)
    );

    // Loaders only read
    cnt_bus_arbiter i_cnt_bus_arbiter (
        .CLK(CLK), .rst_n(rst_n),
        .req_0(sil_req), .we_0(1'b0), .addr_0(sil_addr), .wdata_0('0),
        .gnt_0(sil_gnt), .rvalid_0(sil_rvalid),
        .req_1(sync_req), .we_1(1'b0), .addr_1(sync_addr), .wdata_1('0),
        .gnt_1(sync_gnt), .rvalid_1(sync_rvalid),
        .req_2(pol_req), .we_2(pol_we), .addr_2(pol_addr), .wdata_2(pol_wdata),
        .gnt_2(pol_gnt), .rvalid_2(pol_rvalid),
        .rdata(rdata),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata)
    );

endmodule

`default_nettype wire

//--- tb_controller.sv
`timescale 1ns/1ps
`default_nettype none

`include "controller_config.svh"

module tb_controller;
    import controller_pkg::*;

    localparam int MAX_CYCLES = 2000;  // Worst-case sum of test budgets is about 850
    localparam int SETTLE     = 20;
    localparam int LOAD_WAIT  = 200;

    logic               CLK = 1'b0;
    logic               rst_n;
    logic               thermo;
    logic               mod_segment;
    logic               stm_segment;
    logic [15:0]        stm_cycle;
    logic               mem_we;
    bus_addr_t          mem_addr;
    bus_word_t          mem_wdata;
    bus_word_t          mem_rdata = '0;
    silencer_settings_t silencer_settings;
    logic               silencer_update;
    sync_settings_t     sync_settings;
    logic               sync_update;
    logic               force_fan;

    bus_word_t mem [256];
    bus_addr_t rd_addr_q = '0;
    bus_addr_t wr_log [$];  // First two DUT write addresses
    logic      host_we;
    bus_addr_t host_addr;
    bus_word_t host_wdata;

    integer seed;
    int     cycle_count       = 0;
    int     errors            = 0;
    int     errors_at_start   = 0;
    int     tests_run         = 0;
    int     tests_passed      = 0;
    int     sil_update_cnt    = 0;
    int     sync_update_cnt   = 0;
    int     sil_update_cycle  = 0;
    int     sync_update_cycle = 0;

    controller_top i_controller_top (
        .CLK(CLK), .rst_n(rst_n),
        .thermo(thermo), .mod_segment(mod_segment), .stm_segment(stm_segment),
        .stm_cycle(stm_cycle),
        .mem_we(mem_we), .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
        .silencer_settings(silencer_settings), .silencer_update(silencer_update),
        .sync_settings(sync_settings), .sync_update(sync_update),
        .force_fan(force_fan)
    );

    always #50 CLK = ~CLK;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register memory with two read stages
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always @(posedge CLK) begin
        if (!rst_n) begin
            for (int i = 0; i < 256; i++) begin
                mem[i] <= {8'(i) ^ 8'hc3, 8'(i)};
            end
            mem[`CTL_ADDR_CTL_FLAG] <= '0;  // No flags pending
        end else begin
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
                if (wr_log.size() < 2) begin
                    wr_log.push_back(mem_addr);
                end
            end
            if (host_we) begin
                mem[host_addr] <= host_wdata;  // Host port
            end
        end
        rd_addr_q <= mem_addr;
        mem_rdata <= mem[rd_addr_q];
    end

    // Strobe counters with the cycle of the last one
    always @(negedge CLK) begin
        if (rst_n === 1'b1) begin
            if (silencer_update) begin
                sil_update_cnt++;
                sil_update_cycle = cycle_count;
            end
            if (sync_update) begin
                sync_update_cnt++;
                sync_update_cycle = cycle_count;
            end
        end
    end

    always @(posedge CLK) begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES) begin
            $display("timeout: run stopped after %0d cycles", cycle_count);
            $display("** FAIL **");
            $finish;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic report_mismatch(input string sig, input logic [95:0] exp,
                                   input logic [95:0] got);
        $display("mismatch at %0d ns: %s expected %0h got %0h", $time, sig, exp, got);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error at %0d ns: %s", $time, what);
        errors++;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge CLK);
    endtask

    // Host port write that lands on the next rising edge
    task automatic poke(input bus_addr_t a, input bus_word_t d);
        host_we    = 1'b1;
        host_addr  = a;
        host_wdata = d;
        @(negedge CLK);
        host_we = 1'b0;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic test_reset_state();
        silencer_settings_t exp_sil;
        sync_settings_t     exp_sync;
        int                 waited;
        exp_sil.mode                       = `CTL_SILENCER_MODE_FIXED_STEPS;
        exp_sil.update_rate_intensity      = 16'd1;
        exp_sil.update_rate_phase          = 16'd1;
        exp_sil.completion_steps_intensity = 16'd10;
        exp_sil.completion_steps_phase     = 16'd40;
        exp_sync.sync_time                 = 64'd0;
        exp_sync.base_cnt                  = 32'd10240;
        if (mem_we !== 1'b0) begin
            report_mismatch("mem_we", 96'(0), 96'(mem_we));
        end
        if (silencer_update !== 1'b0) begin
            report_mismatch("silencer_update", 96'(0), 96'(silencer_update));
        end
        if (sync_update !== 1'b0) begin
            report_mismatch("sync_update", 96'(0), 96'(sync_update));
        end
        if (force_fan !== 1'b0) begin
            report_mismatch("force_fan", 96'(0), 96'(force_fan));
        end
        if (silencer_settings !== exp_sil) begin
            report_mismatch("silencer_settings", 96'(exp_sil), 96'(silencer_settings));
        end
        if (sync_settings !== exp_sync) begin
            report_mismatch("sync_settings", 96'(exp_sync), 96'(sync_settings));
        end
        waited = 0;
        while (wr_log.size() < 2 && waited < SETTLE) begin
            @(negedge CLK);
            waited++;
        end
        if (wr_log.size() < 2) begin
            report_failure("fewer than two bus writes after reset");
        end else begin
            if (wr_log[0] !== `CTL_ADDR_VERSION_MINOR) report_mismatch("first write addr",
                96'(`CTL_ADDR_VERSION_MINOR), 96'(wr_log[0]));
            if (wr_log[1] !== `CTL_ADDR_VERSION_MAJOR) report_mismatch("second write addr",
                96'(`CTL_ADDR_VERSION_MAJOR), 96'(wr_log[1]));
        end
        if (mem[`CTL_ADDR_VERSION_MINOR] !== {8'h00, `CTL_VERSION_MINOR}) report_mismatch(
            "mem[VERSION_MINOR]", 96'(`CTL_VERSION_MINOR), 96'(mem[`CTL_ADDR_VERSION_MINOR]));
        if (mem[`CTL_ADDR_VERSION_MAJOR] !== {8'h00, `CTL_VERSION_MAJOR}) report_mismatch(
            "mem[VERSION_MAJOR]", 96'(`CTL_VERSION_MAJOR), 96'(mem[`CTL_ADDR_VERSION_MAJOR]));
        end_test("reset and version");
    endtask

    task automatic test_status_word();
        logic [31:0] r;
        bus_word_t   expected;
        for (int k = 0; k < 6; k++) begin
            r           = $random(seed);
            thermo      = r[0];
            mod_segment = r[1];
            stm_segment = r[2];
            stm_cycle   = r[3] ? 16'h0000 : r[31:16];
            wait_cycles(SETTLE);
            expected    = '0;
            expected[0] = thermo;
            expected[1] = mod_segment;
            expected[2] = stm_segment;
            expected[3] = (stm_cycle == 16'h0000);
            if (mem[`CTL_ADDR_FPGA_STATE] !== expected) begin
                report_mismatch("mem[FPGA_STATE]", 96'(expected), 96'(mem[`CTL_ADDR_FPGA_STATE]));
            end
        end
        end_test("status word");
    endtask

    task automatic run_load_test(input logic use_sync);
        bus_addr_t   base;
        int          nwords;
        int          flag_bit;
        int          waited;
        bus_word_t   word;
        logic [95:0] expected;
        logic [95:0] got;
        base     = use_sync ? `CTL_ADDR_SYNC_BASE : `CTL_ADDR_SILENCER_BASE;
        nwords   = use_sync ? 6 : 5;
        flag_bit = use_sync ? `CTL_FLAG_SYNC_SET : `CTL_FLAG_SILENCER_SET;
        expected = '0;
        for (int i = 0; i < nwords; i++) begin
            word = 16'($random(seed));
            expected[i*16 +: 16] = word;  // Lowest word first
            poke(base + bus_addr_t'(i), word);
        end
        poke(`CTL_ADDR_CTL_FLAG, mem[`CTL_ADDR_CTL_FLAG] | (16'h1 << flag_bit));
        waited = 0;
        while (!(use_sync ? sync_update : silencer_update) && waited < LOAD_WAIT) begin
            @(negedge CLK);
            waited++;
        end
        if (waited >= LOAD_WAIT) begin
            report_failure("update strobe never came");
        end else begin
            if (use_sync) begin
                got = sync_settings;
            end else begin
                got = 96'(silencer_settings);
            end
            if (got !== expected) report_mismatch(use_sync ? "sync_settings" : "silencer_settings",
                                                  expected, got);
        end
        waited = 0;
        while (mem[`CTL_ADDR_CTL_FLAG][flag_bit] !== 1'b0 && waited < SETTLE) begin
            @(negedge CLK);
            waited++;
        end
        if (waited >= SETTLE) report_failure("load flag bit was not cleared in memory");
        end_test(use_sync ? "sync load" : "silencer load");
    endtask

    task automatic test_both_loads();
        int sil_start;
        int sync_start;
        int waited;
        sil_start  = sil_update_cnt;
        sync_start = sync_update_cnt;
        poke(`CTL_ADDR_CTL_FLAG, mem[`CTL_ADDR_CTL_FLAG] |
             (16'h1 << `CTL_FLAG_SILENCER_SET) | (16'h1 << `CTL_FLAG_SYNC_SET));
        waited = 0;
        while ((sync_update_cnt == sync_start ||
                mem[`CTL_ADDR_CTL_FLAG][`CTL_FLAG_SYNC_SET] !== 1'b0) && waited < LOAD_WAIT) begin
            @(negedge CLK);
            waited++;
        end
        wait_cycles(10);  // Room for a stray extra strobe
        if (sil_update_cnt - sil_start != 1) report_mismatch("silencer_update count",
            96'(1), 96'(sil_update_cnt - sil_start));
        if (sync_update_cnt - sync_start != 1) report_mismatch("sync_update count",
            96'(1), 96'(sync_update_cnt - sync_start));
        if (sil_update_cycle >= sync_update_cycle) report_failure("sync was served before silencer");
        if (mem[`CTL_ADDR_CTL_FLAG][`CTL_FLAG_SILENCER_SET] !== 1'b0) begin
            report_failure("silencer flag bit still set after both loads");
        end
        if (mem[`CTL_ADDR_CTL_FLAG][`CTL_FLAG_SYNC_SET] !== 1'b0) begin
            report_failure("sync flag bit still set after both loads");
        end
        end_test("both loads");
    endtask

    task automatic test_force_fan();
        int waited;
        poke(`CTL_ADDR_CTL_FLAG, mem[`CTL_ADDR_CTL_FLAG] | (16'h1 << `CTL_FLAG_FORCE_FAN));
        waited = 0;
        while (force_fan !== 1'b1 && waited < SETTLE) begin
            @(negedge CLK);
            waited++;
        end
        if (waited >= SETTLE) report_failure("force_fan did not rise after the flag was set");
        poke(`CTL_ADDR_CTL_FLAG, mem[`CTL_ADDR_CTL_FLAG] & ~(16'h1 << `CTL_FLAG_FORCE_FAN));
        waited = 0;
        while (force_fan !== 1'b0 && waited < SETTLE) begin
            @(negedge CLK);
            waited++;
        end
        if (waited >= SETTLE) report_failure("force_fan did not fall after the flag was cleared");
        end_test("force fan");
    endtask

    initial begin
        seed        = 32'ha876;
        rst_n       = 1'b0;
        thermo      = 1'b0;
        mod_segment = 1'b0;
        stm_segment = 1'b0;
        stm_cycle   = 16'h0000;
        host_we     = 1'b0;
        host_addr   = '0;
        host_wdata  = '0;
        repeat (3) @(negedge CLK);
        rst_n = 1'b1;

        test_reset_state();
        test_status_word();
        run_load_test(1'b0);
        run_load_test(1'b1);
        test_both_loads();
        test_force_fan();

        $display("%0d of %0d tests passed, %0d errors", tests_passed, tests_run, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sources.f
+incdir+.
controller_pkg.sv
cnt_bus_arbiter.sv
settings_loader.sv
ctl_poller.sv
controller_top.sv
tb_controller.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_controller
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) controller_config.svh
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
